// File: list.f
+incdir+.
dcache_pkg.sv
dcache_request.sv
dcache_way_tags.sv
dcache_pseudo_lru.sv
dcache_hit_check.sv
dcache_lookup_top.sv
tb_dcache_lookup.sv

// File: run.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and search the log for the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dcache_lookup -f list.f -o tb_dcache_lookup
./obj_dir/tb_dcache_lookup > sim.log 2>&1 || true
cat sim.log
if grep -q "^Simulation completed successfully$" sim.log
then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// File: tb_dcache_lookup.sv
// Directed testbench for the cache tag lookup with reference model, LCG, Wishbone tasks and tests
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache_lookup;

	localparam int ACK_TIMEOUT = 20;
	localparam logic READ = 1'b0;
	localparam logic WRITE = 1'b1;
	localparam logic [31:0] INSTALL = 32'h0000_0001;
	localparam logic [31:0] INVALIDATE = 32'h0000_0000;
	localparam logic [31:0] IO_REPLY = 32'h1 << `RESULT_IO_BIT;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic wb_ack;

	// Reference model of tags, valid bits and tree bits
	logic [`DCACHE_TAG_BITS - 1:0] ref_tag[`DCACHE_SETS][`DCACHE_WAYS];
	logic ref_valid[`DCACHE_SETS][`DCACHE_WAYS];
	logic [2:0] ref_tree[`DCACHE_SETS];

	int error_count;
	int check_count;
	logic [31:0] lcg_state;

	dcache_lookup_top i_dut (
		.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Byte address from tag, set and offset fields
	function automatic logic [31:0] make_addr(input logic [21:0] tag, input logic [3:0] set_idx,
		input logic [5:0] offset);
		return {tag, set_idx, offset};
	endfunction

	// Hit reply for a given way
	function automatic logic [31:0] hit_reply(input int way);
		logic [31:0] reply;
		reply = '0;
		reply[`RESULT_HIT_BIT] = 1'b1;
		reply[`RESULT_WAY_LSB +: `RESULT_WAY_BITS] = way[1:0];
		return reply;
	endfunction

	// Way holding the address tag in the model or -1 when absent
	function automatic int find_way(input logic [31:0] addr);
		for (int way = 0; way < `DCACHE_WAYS; way++)
			if (ref_valid[addr[9:6]][way] && ref_tag[addr[9:6]][way] == addr[31:10])
				return way;
		return -1;
	endfunction

	// Tree walk where the root picks the pair
	function automatic int pick_victim(input logic [3:0] set_idx);
		if (ref_tree[set_idx][0])
			return ref_tree[set_idx][2] ? 3 : 2;
		return ref_tree[set_idx][1] ? 1 : 0;
	endfunction

	// Root points to the other pair and the pair bit to the sibling
	function automatic void touch_way(input logic [3:0] set_idx, input int way);
		ref_tree[set_idx][0] = way < 2;
		if (way < 2)
			ref_tree[set_idx][1] = way == 0;
		else
			ref_tree[set_idx][2] = way == 2;
	endfunction

	// Expected reply while the model state moves on as the DUT should
	function automatic logic [31:0] predict_reply(input logic we, input logic [31:0] addr,
		input logic [31:0] wdata);
		logic [3:0] set_idx;
		int way;
		logic [31:0] reply;
		set_idx = addr[9:6];
		way = find_way(addr);
		reply = '0;
		// Uncached region does no lookup and changes no state
		if (addr[31:16] == 16'hffff)
			return IO_REPLY;
		if (way >= 0)
			reply = hit_reply(way);
		if (!we)
		begin
			if (way >= 0)
				touch_way(set_idx, way);
		end
		else if (wdata[0])
		begin
			// Present tag keeps its way
			if (way < 0)
				way = pick_victim(set_idx);
			ref_tag[set_idx][way] = addr[31:10];
			ref_valid[set_idx][way] = 1'b1;
			touch_way(set_idx, way);
		end
		else if (way >= 0)
			ref_valid[set_idx][way] = 1'b0;
		return reply;
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// One Wishbone classic cycle with stb held until ack
	task automatic bus_transfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int edges;
		@(negedge clk);
		// Ack of the previous cycle lasts one cycle only
		check_count++;
		assert (!wb_ack)
		else
		begin
			error_count++;
			$display("Fail at %0t: wb_ack high before the cycle starts", $time);
		end
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = addr;
		wb_wdata = wdata;
		edges = 0;
		do
		begin
			@(negedge clk);
			edges++;
		end
		while (!wb_ack && edges < ACK_TIMEOUT);
		if (!wb_ack)
		begin
			error_count++;
			$display("No wb_ack within %0d cycles for address %h, giving up", ACK_TIMEOUT, addr);
			finish_run();
		end
		check_count++;
		assert (edges == 2)
		else
		begin
			error_count++;
			$display("Fail at %0t: ack after %0d rising edges, expected 2", $time, edges);
		end
		rdata = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Cycle plus compare against the model
	task automatic transfer_check(input logic we, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] got);
		logic [31:0] expected;
		expected = predict_reply(we, addr, wdata);
		bus_transfer(we, addr, wdata, got);
		check_count++;
		assert (got == expected)
		else
		begin
			error_count++;
			$display("Fail at %0t: %s of %h replied %h, expected %h", $time,
				we ? "write" : "read", addr, got, expected);
		end
	endtask

	task automatic expect_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		check_count++;
		assert (got == expected)
		else
		begin
			error_count++;
			$display("Fail at %0t: %s gave %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic reads_miss_after_reset();
		logic [31:0] got;
		for (int i = 0; i < 4; i++)
		begin
			transfer_check(READ, make_addr(22'h1000 + 22'(i), 4'(i * 3), 6'(i * 5)), '0, got);
			expect_value(got, '0, "read after reset");
		end
	endtask

	task automatic install_and_hit();
		logic [31:0] got;
		transfer_check(WRITE, make_addr(22'h2a5, 4'd5, 6'd4), INSTALL, got);
		expect_value(got, '0, "install into an empty set");
		// A fresh set starts in way 0
		transfer_check(READ, make_addr(22'h2a5, 4'd5, 6'd60), '0, got);
		expect_value(got, hit_reply(0), "read after install");
		// Upper write data bits are ignored
		transfer_check(WRITE, make_addr(22'h2a5, 4'd5, 6'd8), 32'hffff_0001, got);
		expect_value(got, hit_reply(0), "second install of a present tag");
	endtask

	task automatic fill_and_evict();
		logic [31:0] got;
		int victim;
		for (int i = 0; i < 4; i++)
			transfer_check(WRITE, make_addr(22'h300 + 22'(i), 4'd9, 6'd0), INSTALL, got);
		// Hits in between move the victim
		transfer_check(READ, make_addr(22'h300, 4'd9, 6'd1), '0, got);
		transfer_check(READ, make_addr(22'h302, 4'd9, 6'd2), '0, got);
		victim = pick_victim(4'd9);
		transfer_check(WRITE, make_addr(22'h304, 4'd9, 6'd3), INSTALL, got);
		transfer_check(READ, make_addr(22'h304, 4'd9, 6'd4), '0, got);
		expect_value(got, hit_reply(victim), "fifth tag in the predicted victim");
		for (int i = 0; i < 5; i++)
			transfer_check(READ, make_addr(22'h300 + 22'(i), 4'd9, 6'(i)), '0, got);
		transfer_check(WRITE, make_addr(22'h305, 4'd9, 6'd5), INSTALL, got);
		for (int i = 0; i < 6; i++)
			transfer_check(READ, make_addr(22'h300 + 22'(i), 4'd9, 6'(i)), '0, got);
	endtask

	task automatic invalidate_and_miss();
		logic [31:0] got;
		int victim;
		transfer_check(WRITE, make_addr(22'h400, 4'd11, 6'd0), INSTALL, got);
		transfer_check(WRITE, make_addr(22'h400, 4'd11, 6'd12), INVALIDATE, got);
		expect_value(got, hit_reply(0), "invalidate of a present tag");
		transfer_check(READ, make_addr(22'h400, 4'd11, 6'd20), '0, got);
		expect_value(got, '0, "read after invalidate");
		// An absent tag leaves the tree as it was
		victim = pick_victim(4'd11);
		transfer_check(WRITE, make_addr(22'h401, 4'd11, 6'd0), INVALIDATE, got);
		expect_value(got, '0, "invalidate of an absent tag");
		transfer_check(WRITE, make_addr(22'h402, 4'd11, 6'd0), INSTALL, got);
		transfer_check(READ, make_addr(22'h402, 4'd11, 6'd7), '0, got);
		expect_value(got, hit_reply(victim), "victim after an absent invalidate");
	endtask

	task automatic io_leaves_tags();
		logic [31:0] got;
		int victim;
		transfer_check(READ, 32'hffff_1234, '0, got);
		expect_value(got, IO_REPLY, "I/O read");
		// Set field 5 is the set of the cached tag 2a5
		transfer_check(WRITE, 32'hffff_0140, INSTALL, got);
		expect_value(got, IO_REPLY, "I/O install");
		transfer_check(WRITE, 32'hffff_0140, INVALIDATE, got);
		expect_value(got, IO_REPLY, "I/O invalidate");
		transfer_check(READ, make_addr(22'h2a5, 4'd5, 6'd0), '0, got);
		expect_value(got, hit_reply(0), "cached set after I/O writes");
		// An I/O install taken by mistake would have moved the victim of set 5
		victim = pick_victim(4'd5);
		transfer_check(WRITE, make_addr(22'h2a6, 4'd5, 6'd0), INSTALL, got);
		transfer_check(READ, make_addr(22'h2a6, 4'd5, 6'd16), '0, got);
		expect_value(got, hit_reply(victim), "victim after I/O writes");
	endtask

	// Eight tags over two sets with the op taken from the top bits
	task automatic random_operations();
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] got;
		for (int i = 0; i < 200; i++)
		begin
			r = next_random();
			addr = make_addr({19'h0a5c, r[29:27]}, {3'b011, r[26]}, r[25:20]);
			// About one in eight to the I/O region
			if (r[19:17] == 3'd0)
				addr[31:16] = 16'hffff;
			// 0 and 1 read, 2 install, 3 invalidate
			transfer_check(r[31], addr, {r[15:0], r[15:1], !r[30]}, got);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		error_count = 0;
		check_count = 0;
		lcg_state = 32'hb7b0_2625;
		for (int s = 0; s < `DCACHE_SETS; s++)
		begin
			ref_tree[s] = 3'b000;
			for (int w = 0; w < `DCACHE_WAYS; w++)
			begin
				ref_tag[s][w] = '0;
				ref_valid[s][w] = 1'b0;
			end
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;
		reads_miss_after_reset();
		install_and_hit();
		fill_and_evict();
		invalidate_and_miss();
		io_leaves_tags();
		random_operations();
		finish_run();
	end

endmodule

// File: dcache_lookup_top.sv
// Tag lookup top level with request stage, way tag banks, hit checker and pseudo-LRU
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_lookup_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [31:0] wb_adr,
	input  logic [31:0] wb_wdata,
	output logic [31:0] wb_rdata,
	output logic        wb_ack
);

	// Request stage to tag banks and checker
	logic read_en;
	dcache_pkg::l1d_set_idx_t read_set;
	dcache_pkg::l1d_set_idx_t lru_set;
	logic check_en;
	dcache_pkg::l1d_addr_u check_addr;
	logic check_write;
	logic check_valid_bit;
	logic check_io;

	// Tag banks to checker
	dcache_pkg::l1d_tag_t way_tag[`DCACHE_WAYS];
	logic way_valid[`DCACHE_WAYS];

	// Checker back to banks and LRU
	logic [`DCACHE_WAYS - 1:0] update_en_oh;
	dcache_pkg::l1d_set_idx_t update_set;
	dcache_pkg::l1d_tag_t update_tag;
	logic update_valid;
	logic lru_update_en;
	dcache_pkg::l1d_set_idx_t lru_update_set;
	dcache_pkg::l1d_way_idx_t lru_update_way;
	dcache_pkg::l1d_way_idx_t victim_way;

	dcache_request i_request (
		.clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_ack,
		.read_en, .read_set, .lru_set, .check_en, .check_addr,
		.check_write, .check_valid_bit, .check_io
	);

	// One tag bank per way, all read the same set in parallel
	for (genvar way = 0; way < `DCACHE_WAYS; way++)
	begin : g_way
		dcache_way_tags i_way_tags (
			.clk,
			.reset,
			.read_en,
			.read_set,
			.write_en(update_en_oh[way]),
			.write_set(update_set),
			.write_tag(update_tag),
			.write_valid(update_valid),
			.read_tag(way_tag[way]),
			.read_valid(way_valid[way])
		);
	end

	dcache_hit_check i_hit_check (
		.clk, .reset, .check_en, .check_addr, .check_write, .check_valid_bit,
		.check_io, .way_tag, .way_valid, .victim_way, .update_en_oh, .update_set,
		.update_tag, .update_valid, .lru_update_en, .lru_update_set,
		.lru_update_way, .wb_rdata, .wb_ack
	);

	// Victim follows the held request set, updates come from the checker
	dcache_pseudo_lru i_lru (
		.clk,
		.reset,
		.lru_set,
		.update_en(lru_update_en),
		.update_set(lru_update_set),
		.update_way(lru_update_way),
		.victim_way
	);

endmodule

// File: dcache_hit_check.sv
// Tag compare over all ways, update way choice, LRU update and registered Wishbone reply
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_hit_check (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      check_en,
	input  dcache_pkg::l1d_addr_u     check_addr,
	input  logic                      check_write,
	input  logic                      check_valid_bit,
	input  logic                      check_io,
	input  dcache_pkg::l1d_tag_t      way_tag[`DCACHE_WAYS],
	input  logic                      way_valid[`DCACHE_WAYS],
	input  dcache_pkg::l1d_way_idx_t  victim_way,
	output logic [`DCACHE_WAYS - 1:0] update_en_oh,
	output dcache_pkg::l1d_set_idx_t  update_set,
	output dcache_pkg::l1d_tag_t      update_tag,
	output logic                      update_valid,
	output logic                      lru_update_en,
	output dcache_pkg::l1d_set_idx_t  lru_update_set,
	output dcache_pkg::l1d_way_idx_t  lru_update_way,
	output logic [31:0]               wb_rdata,
	output logic                      wb_ack
);

	logic [`DCACHE_WAYS - 1:0] hit_oh;
	logic any_hit;
	logic is_install;
	dcache_pkg::l1d_way_idx_t hit_way;
	dcache_pkg::l1d_way_idx_t target_way;
	logic [31:0] rdata_nxt;

	// Compare every way, I/O requests never hit
	always_comb
	begin
		hit_oh = '0;
		hit_way = '0;
		for (int way = 0; way < `DCACHE_WAYS; way++)
		begin
			hit_oh[way] = check_en && !check_io && way_valid[way]
				&& way_tag[way] == check_addr.fields.tag;
			if (hit_oh[way])
				hit_way = dcache_pkg::l1d_way_idx_t'(way);
		end
	end

	assign any_hit = |hit_oh;
	assign is_install = check_write && check_valid_bit;

	// Present tag keeps its way, a miss takes the LRU victim
	assign target_way = any_hit ? hit_way : victim_way;

	// Tag bank write, committed on the reply edge
	always_comb
	begin
		update_en_oh = '0;
		if (check_en && !check_io && check_write)
		begin
			if (is_install)
				update_en_oh[target_way] = 1'b1;
			else
				// Invalidate only where the tag sits, absent tag writes nothing
				update_en_oh = hit_oh;
		end
	end

	assign update_set = check_addr.fields.set_idx;
	assign update_tag = check_addr.fields.tag;
	assign update_valid = check_valid_bit;

	// Read hits and installs touch the tree, target equals hit way on a hit
	assign lru_update_en = check_en && !check_io && (is_install || (!check_write && any_hit));
	assign lru_update_set = check_addr.fields.set_idx;
	assign lru_update_way = target_way;

	// Reply reports the lookup as found, before any update of this cycle
	always_comb
	begin
		rdata_nxt = '0;
		rdata_nxt[`RESULT_HIT_BIT] = any_hit;
		rdata_nxt[`RESULT_WAY_LSB +: `RESULT_WAY_BITS] = any_hit ? hit_way : '0;
		rdata_nxt[`RESULT_IO_BIT] = check_io;
	end

	// Registered reply, ack high for exactly one cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			wb_rdata <= '0;
		end
		else
		begin
			wb_ack <= check_en;
			if (check_en)
				wb_rdata <= rdata_nxt;
		end
	end

	// A tag lives in at most one way of a set
	hit_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_oh))
		else $error("tag found in more than one way");

	update_unique: assert property (@(posedge clk) disable iff (reset) $onehot0(update_en_oh))
		else $error("more than one way written in one cycle");

endmodule

// File: dcache_pseudo_lru.sv
// Per-set three-bit tree pseudo-LRU with victim select and access update
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_pseudo_lru (
	input  logic                      clk,
	input  logic                      reset,
	input  dcache_pkg::l1d_set_idx_t  lru_set,
	input  logic                      update_en,
	input  dcache_pkg::l1d_set_idx_t  update_set,
	input  dcache_pkg::l1d_way_idx_t  update_way,
	output dcache_pkg::l1d_way_idx_t  victim_way
);

	// Tree bit positions
	// Root picks the pair, the other two pick within a pair
	localparam int TREE_ROOT = 0;
	localparam int TREE_LOW = 1;
	localparam int TREE_HIGH = 2;

	logic [2:0] tree_bits[`DCACHE_SETS];
	logic [2:0] cur_bits;

	assign cur_bits = tree_bits[lru_set];

	// Walk the tree for the current request's set
	always_comb
	begin
		if (cur_bits[TREE_ROOT])
		begin
			// Ways 2 and 3
			victim_way = {1'b1, cur_bits[TREE_HIGH]};
		end
		else
		begin
			// Ways 0 and 1
			victim_way = {1'b0, cur_bits[TREE_LOW]};
		end
	end

	// Touch rule, point every bit on the path away from the used way
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// All zero, way 0 is the first victim
			for (int set_idx = 0; set_idx < `DCACHE_SETS; set_idx++)
				tree_bits[set_idx] <= 3'b000;
		end
		else if (update_en)
		begin
			// Root to the other pair
			tree_bits[update_set][TREE_ROOT] <= !update_way[1];

			// Pair bit to the sibling of the touched way
			if (update_way[1])
				tree_bits[update_set][TREE_HIGH] <= !update_way[0];
			else
				tree_bits[update_set][TREE_LOW] <= !update_way[0];
		end
	end

endmodule

// File: dcache_way_tags.sv
// Tag RAM and valid bits of one cache way with one registered read port and one write port
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_way_tags (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      read_en,
	input  dcache_pkg::l1d_set_idx_t  read_set,
	input  logic                      write_en,
	input  dcache_pkg::l1d_set_idx_t  write_set,
	input  dcache_pkg::l1d_tag_t      write_tag,
	input  logic                      write_valid,
	output dcache_pkg::l1d_tag_t      read_tag,
	output logic                      read_valid
);

	// Tag storage, contents only meaningful when the valid bit is set
	dcache_pkg::l1d_tag_t tag_mem[`DCACHE_SETS];

	// Line valid bits per set
	logic line_valid[`DCACHE_SETS];

	// Tag RAM write and registered read
	always_ff @(posedge clk)
	begin
		if (write_en)
			tag_mem[write_set] <= write_tag;

		if (read_en)
			read_tag <= tag_mem[read_set];
	end

	// Valid bits start cleared so every set misses after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int set_idx = 0; set_idx < `DCACHE_SETS; set_idx++)
				line_valid[set_idx] <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			// Install sets it, invalidate clears it
			if (write_en)
				line_valid[write_set] <= write_valid;

			// Reads and writes never overlap, so no bypass
			if (read_en)
				read_valid <= line_valid[read_set];
		end
	end

endmodule

// File: dcache_request.sv
// Wishbone slave request stage with busy flag, I/O decode and tag read start
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_request (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  dcache_pkg::l1d_addr_u     wb_adr,
	input  logic [31:0]               wb_wdata,
	input  logic                      wb_ack,
	output logic                      read_en,
	output dcache_pkg::l1d_set_idx_t  read_set,
	output dcache_pkg::l1d_set_idx_t  lru_set,
	output logic                      check_en,
	output dcache_pkg::l1d_addr_u     check_addr,
	output logic                      check_write,
	output logic                      check_valid_bit,
	output logic                      check_io
);

	logic busy;
	logic accept;
	logic io_addr;

	// A new cycle is taken only when no request is in flight
	assign accept = wb_cyc && wb_stb && !busy;

	// Uncached region decoded from the raw address word
	assign io_addr = wb_adr.raw[31 -: `DCACHE_IO_BITS] == `DCACHE_IO_PREFIX;

	// Tag banks register their entry on the accepting edge
	// I/O cycles leave the tag RAMs idle
	assign read_en = accept && !io_addr;
	assign read_set = wb_adr.fields.set_idx;

	// Control state
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			check_en <= 1'b0;
		end
		else
		begin
			// One check cycle per accepted request
			check_en <= accept;

			// Ack ends the request and the master drops stb after it
			if (accept)
				busy <= 1'b1;
			else if (wb_ack)
				busy <= 1'b0;
		end
	end

	// Request payload held for the whole request
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			check_addr <= wb_adr;
			check_write <= wb_we;
			// Write data bit 0 picks install or invalidate
			check_valid_bit <= wb_wdata[0];
			check_io <= io_addr;
			lru_set <= wb_adr.fields.set_idx;
		end
	end

	// Busy must cover the request up to its ack so a held stb is not taken twice
	busy_until_ack: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> busy)
		else $error("wb_ack seen with no request in flight");

endmodule

// File: dcache_pkg.sv
// Address union and way, set and tag index types for the data cache tag lookup
`include "dcache_config.svh"

package dcache_pkg;

	// Index and tag types
	typedef logic [$clog2(`DCACHE_WAYS) - 1:0] l1d_way_idx_t;
	typedef logic [`DCACHE_SET_BITS - 1:0] l1d_set_idx_t;
	typedef logic [`DCACHE_TAG_BITS - 1:0] l1d_tag_t;

	// Byte address, raw word for the I/O check
	// Field view for set and tag lookup
	typedef union packed
	{
		logic [31:0] raw;
		struct packed
		{
			l1d_tag_t tag;
			l1d_set_idx_t set_idx;
			logic [`DCACHE_OFFSET_BITS - 1:0] offset;
		} fields;
	} l1d_addr_u;

endpackage

// File: dcache_config.svh
// Cache geometry, address field widths, I/O region and reply word bit positions
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Geometry, the tree LRU only covers four ways
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// Byte address split, tag takes what is left of 32 bits
`define DCACHE_OFFSET_BITS 6
`define DCACHE_SET_BITS 4
`define DCACHE_TAG_BITS 22

// Uncached I/O region, top address bits all ones
`define DCACHE_IO_BITS 16
`define DCACHE_IO_PREFIX {`DCACHE_IO_BITS{1'b1}}

// Reply word layout, unused bits read as zero
`define RESULT_HIT_BIT 0
`define RESULT_WAY_LSB 1
`define RESULT_WAY_BITS 2
`define RESULT_IO_BIT 3

`endif
